// File: flist.f
+incdir+.
radar_word_pkg.sv
radar_seq_pkg.sv
param_shadow.sv
pulse_sequencer.sv
radar_pulse_ctrl.sv
tb_radar_pulse_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the radar pulse controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f flist.f --top-module tb_radar_pulse_ctrl -o sim_radar

./obj_dir/sim_radar 2>&1 | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi

// File: tb_radar_pulse_ctrl.sv
`timescale 1ns/1ps

`include "radar_cfg.svh"

module tb_radar_pulse_ctrl;

  import radar_word_pkg::*;

  // dac chirp length, two interval counts and the adc collect length
  localparam int DAC_LEN      = 9;
  localparam int N_FIRST      = 12;
  localparam int N_SECOND     = 30;
  localparam int M_SAMPLES    = 20;
  localparam int HOLD_CYCLES  = 200;
  // one chirp cycle with margin
  localparam int CYCLE_BUDGET = DAC_LEN + M_SAMPLES + N_SECOND + 40;
  localparam int TOTAL_BUDGET = 20 + 40 + HOLD_CYCLES + 10 * CYCLE_BUDGET;
  // process and overhead plus one idle and the extra active cycle
  localparam int GAP_FIXED = `RADAR_PROCESS_CYCLES + `RADAR_OVERHEAD_CYCLES + 2;
  // chirp words out of reset with the ctrl word on top
  localparam chirp_params_t RESET_WORDS = {`RADAR_CHIRP_CTRL_INIT,
    `RADAR_CHIRP_FREQ_OFFSET_INIT, `RADAR_CHIRP_TUNING_INIT, `RADAR_CHIRP_COUNTER_MAX_INIT};

  logic          aclk;
  logic          aresetn;
  chirp_params_t chirp_params_in;
  chirp_params_t chirp_params_out;
  timing_cfg_t   timing_in;
  logic          chirp_ready;
  logic          chirp_active = 1'b0;
  logic          chirp_done = 1'b0;
  logic          chirp_init;
  logic          chirp_enable;
  logic          adc_enable;

  int          dac_cnt;
  logic [31:0] lfsr_state = 32'h41659fa2;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err_start;

  radar_pulse_ctrl i_radar_pulse_ctrl (.*);

  initial begin
    aclk = 1'b0;
    forever #2 aclk = ~aclk;
  end

  // run limit of twice the summed test budgets
  initial begin
    #(TOTAL_BUDGET * 2 * 4);
    $display("watchdog expired after %0d cycles, the run did not finish", TOTAL_BUDGET * 2);
    $display("STATUS: FAIL");
    $finish;
  end

  ////////////////////
  // dac model
  ////////////////////

  // active for DAC_LEN cycles after init and then a done strobe
  always @(posedge aclk) begin
    if (!aresetn) begin
      chirp_active <= 1'b0;
      chirp_done   <= 1'b0;
      dac_cnt      <= 0;
    end else begin
      chirp_done <= 1'b0;
      if (chirp_init) begin
        chirp_active <= 1'b1;
        dac_cnt      <= DAC_LEN;
      end else if (chirp_active && dac_cnt == 1) begin
        chirp_active <= 1'b0;
        chirp_done   <= 1'b1;
      end else if (chirp_active) begin
        dac_cnt <= dac_cnt - 1;
      end
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic radar_word_t random_word();
    radar_word_t w;
    w = '0;
    for (int i = 0; i < `RADAR_WORD_W; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      w = {w[`RADAR_WORD_W-2:0], lfsr_state[0]};
    end
    return w;
  endfunction

  // interval int word stays zero as n fits the fraction word
  function automatic timing_cfg_t timing_words(int n, int m);
    return '{interval_int: '0, interval_frac: radar_word_t'(n), adc_samples: radar_word_t'(m)};
  endfunction

  // select 0 is init, 1 is enable and anything else done
  function automatic logic probe(int sel);
    case (sel)
      0: return chirp_init;
      1: return chirp_enable;
      default: return chirp_done;
    endcase
  endfunction

  task automatic check_params(string name, chirp_params_t got, chirp_params_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_level(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_count(string name, radar_word_t got, radar_word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  // falling-edge samples until the output reaches val
  // cycles counts the samples taken
  task automatic wait_until(string name, int sel, logic val, output int cycles);
    cycles = 0;
    do begin
      @(negedge aclk);
      cycles++;
    end while (probe(sel) !== val && cycles < CYCLE_BUDGET);
    if (probe(sel) !== val) begin
      errors++;
      $display("timed out after %0d cycles waiting for %s to become %0b", cycles, name, val);
    end
  endtask

  // chirp_enable low window and the adc_enable high samples inside it
  task automatic measure_gap(output int gap, output int adc_cycles);
    int n;
    gap = 0;
    adc_cycles = 0;
    wait_until("chirp_enable", 1, 1'b1, n);
    wait_until("chirp_enable", 1, 1'b0, n);
    while (chirp_enable === 1'b0 && gap < CYCLE_BUDGET) begin
      gap++;
      if (adc_enable) begin
        adc_cycles++;
      end
      @(negedge aclk);
    end
  endtask

  task automatic begin_test();
    test_err_start = errors;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (errors == test_err_start) begin
      $display("test %s passed", name);
    end else begin
      tests_failed++;
      $display("test %s failed, %0d checks wrong", name, errors - test_err_start);
    end
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reset_values();
    begin_test();
    repeat (4) begin
      @(negedge aclk);
      check_level("chirp_init", chirp_init, 1'b0);
      check_level("chirp_enable", chirp_enable, 1'b0);
      check_level("adc_enable", adc_enable, 1'b0);
      check_params("chirp_params_out", chirp_params_out, RESET_WORDS);
    end
    end_test("reset_values");
  endtask

  // new word lands on the fourth sample after the drive edge
  task automatic test_shadow_delay();
    chirp_params_t word;
    chirp_params_t old;
    begin_test();
    for (int k = 0; k < 4; k++) begin
      old = chirp_params_out;
      for (int j = 0; j < 4; j++) begin
        word = {word[3*`RADAR_WORD_W-1:0], random_word()};
      end
      @(posedge aclk);
      chirp_params_in <= word;
      repeat (3) begin
        @(negedge aclk);
        check_params("chirp_params_out", chirp_params_out, old);
      end
      repeat (4) begin
        @(negedge aclk);
        check_params("chirp_params_out", chirp_params_out, word);
      end
    end
    end_test("shadow_delay");
  endtask

  task automatic test_chirp_handshake();
    int n;
    begin_test();
    @(posedge aclk);
    chirp_ready <= 1'b1;
    // init is already up on the first enable sample
    wait_until("chirp_enable", 1, 1'b1, n);
    check_level("chirp_init", chirp_init, 1'b1);
    @(negedge aclk);
    check_level("chirp_init", chirp_init, 1'b0);
    check_level("chirp_enable", chirp_enable, 1'b1);
    // enable holds one cycle past the done strobe
    wait_until("chirp_done", 2, 1'b1, n);
    @(negedge aclk);
    check_level("chirp_enable", chirp_enable, 1'b1);
    @(negedge aclk);
    check_level("chirp_enable", chirp_enable, 1'b0);
    end_test("chirp_handshake");
  endtask

  task automatic test_cycle_gap();
    int gap;
    int adc_cycles;
    begin_test();
    repeat (2) begin
      measure_gap(gap, adc_cycles);
      check_count("chirp_enable gap", radar_word_t'(gap),
                  radar_word_t'(M_SAMPLES + N_FIRST + GAP_FIXED));
      check_count("adc_enable cycles", radar_word_t'(adc_cycles), radar_word_t'(M_SAMPLES));
    end
    end_test("cycle_gap");
  endtask

  task automatic test_ready_hold();
    int n;
    begin_test();
    wait_until("chirp_enable", 1, 1'b0, n);
    @(posedge aclk);
    chirp_ready <= 1'b0;
    n = 0;
    repeat (HOLD_CYCLES) begin
      @(negedge aclk);
      if (chirp_init) begin
        n++;
      end
    end
    check_count("chirp_init pulses", radar_word_t'(n), '0);
    @(posedge aclk);
    chirp_ready <= 1'b1;
    // idle plus N+1 active cycles plus the output register and the sample edge
    wait_until("chirp_init", 0, 1'b1, n);
    check_count("ready to chirp_init", radar_word_t'(n), radar_word_t'(N_FIRST + 4));
    end_test("ready_hold");
  endtask

  // interval changed mid chirp applies to the gap after this chirp
  task automatic test_interval_change();
    int gap;
    int adc_cycles;
    begin_test();
    @(posedge aclk);
    timing_in <= timing_words(N_SECOND, M_SAMPLES);
    measure_gap(gap, adc_cycles);
    check_count("chirp_enable gap", radar_word_t'(gap),
                radar_word_t'(M_SAMPLES + N_SECOND + GAP_FIXED));
    end_test("interval_change");
  endtask

  initial begin
    aresetn         = 1'b0;
    chirp_ready     = 1'b0;
    chirp_params_in = RESET_WORDS;
    timing_in       = timing_words(N_FIRST, M_SAMPLES);
    repeat (8) @(posedge aclk);
    aresetn <= 1'b1;
    test_reset_values();
    test_shadow_delay();
    test_chirp_handshake();
    test_cycle_gap();
    test_ready_hold();
    test_interval_change();
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: radar_pulse_ctrl.sv
`timescale 1ns/1ps

module radar_pulse_ctrl (
  input  logic                          aclk,
  input  logic                          aresetn,
  // register-map words
  input  radar_word_pkg::chirp_params_t chirp_params_in,
  input  radar_word_pkg::timing_cfg_t   timing_in,
  // shadowed chirp shape to the dac
  output radar_word_pkg::chirp_params_t chirp_params_out,
  // dac handshake levels and strobes
  input  logic                          chirp_ready,
  input  logic                          chirp_active,
  input  logic                          chirp_done,
  output logic                          chirp_init,
  output logic                          chirp_enable,
  // adc capture window
  output logic                          adc_enable
);

  import radar_word_pkg::*;

  // timing words after change filtering
  timing_cfg_t timing_shadowed;

  ////////////////////
  // parameter shadows
  ////////////////////

  // chirp shape goes straight out to the dac
  param_shadow #(
    .payload_t  (chirp_params_t),
    .RESET_VALUE(CHIRP_PARAMS_RESET)
  ) chirp_shadow (
    .aclk   (aclk),
    .aresetn(aresetn),
    .din    (chirp_params_in),
    .dout   (chirp_params_out),
    .updated()
  );

  // interval and sample count feed the sequencer
  param_shadow #(
    .payload_t  (timing_cfg_t),
    .RESET_VALUE(TIMING_CFG_RESET)
  ) timing_shadow (
    .aclk   (aclk),
    .aresetn(aresetn),
    .din    (timing_in),
    .dout   (timing_shadowed),
    .updated()
  );

  ////////////////////
  // chirp cycle
  ////////////////////

  pulse_sequencer i_pulse_sequencer (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .timing      (timing_shadowed),
    .chirp_ready (chirp_ready),
    .chirp_active(chirp_active),
    .chirp_done  (chirp_done),
    .chirp_init  (chirp_init),
    .chirp_enable(chirp_enable),
    .adc_enable  (adc_enable)
  );

endmodule

// File: pulse_sequencer.sv
`timescale 1ns/1ps

`include "radar_cfg.svh"

module pulse_sequencer (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  radar_word_pkg::timing_cfg_t timing,
  input  logic                        chirp_ready,
  input  logic                        chirp_active,
  input  logic                        chirp_done,
  output logic                        chirp_init,
  output logic                        chirp_enable,
  output logic                        adc_enable
);

  import radar_word_pkg::*;
  import radar_seq_pkg::*;

  seq_state_t  state;
  seq_state_t  next_state;

  // limits taken from the shadowed timing words
  interval_t   interval_max;
  radar_word_t collect_max;

  // per-cycle down counters
  interval_t   interval_cnt;
  radar_word_t collect_cnt;
  dwell_cnt_t  process_cnt;
  dwell_cnt_t  overhead_cnt;

  ////////////////////
  // timing limits
  ////////////////////

  // one register stage after the shadow
  // picked up by the counters in the next idle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      interval_max <= {TIMING_CFG_RESET.interval_int, TIMING_CFG_RESET.interval_frac};
      collect_max  <= TIMING_CFG_RESET.adc_samples;
    end else begin
      interval_max <= {timing.interval_int, timing.interval_frac};
      collect_max  <= timing.adc_samples;
    end
  end

  ////////////////////
  // dwell counters
  ////////////////////

  // pulse repetition interval counts to zero then waits on ready
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      interval_cnt <= '0;
    end else if (state == ACTIVE && interval_cnt != '0) begin
      interval_cnt <= interval_cnt - 1'b1;
    end else if (state == IDLE) begin
      interval_cnt <= interval_max;
    end
  end

  // adc collect length
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      collect_cnt <= '0;
    end else if (state == COLLECT && collect_cnt != '0) begin
      collect_cnt <= collect_cnt - 1'b1;
    end else if (state == IDLE) begin
      collect_cnt <= collect_max;
    end
  end

  // processing dwell
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      process_cnt <= '0;
    end else if (state == PROCESS && process_cnt != '0) begin
      process_cnt <= process_cnt - 1'b1;
    end else if (state == IDLE) begin
      process_cnt <= dwell_cnt_t'(`RADAR_PROCESS_CYCLES);
    end
  end

  // clean-up dwell before the next idle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      overhead_cnt <= '0;
    end else if (state == OVERHEAD && overhead_cnt != '0) begin
      overhead_cnt <= overhead_cnt - 1'b1;
    end else if (state == IDLE) begin
      overhead_cnt <= dwell_cnt_t'(`RADAR_OVERHEAD_CYCLES);
    end
  end

  ////////////////////
  // chirp cycle FSM
  ////////////////////

  always_comb begin
    next_state = state;
    case (state)
      // one cycle here to load the counters
      IDLE: begin
        if (chirp_ready) begin
          next_state = ACTIVE;
        end
      end
      // leave once the interval runs out and the dac is ready
      ACTIVE: begin
        if (chirp_ready && interval_cnt == '0) begin
          next_state = CHIRP;
        end
      end
      // dac signals the end of the chirp
      CHIRP: begin
        if (chirp_done) begin
          next_state = COLLECT;
        end
      end
      // exit on 1 so the stay is exactly the sample count
      COLLECT: begin
        if (collect_cnt == radar_word_t'(1)) begin
          next_state = PROCESS;
        end
      end
      PROCESS: begin
        if (process_cnt == dwell_cnt_t'(1)) begin
          next_state = OVERHEAD;
        end
      end
      OVERHEAD: begin
        if (overhead_cnt == dwell_cnt_t'(1)) begin
          next_state = IDLE;
        end
      end
      // unused codes fall back to idle
      default: begin
        next_state = IDLE;
      end
    endcase
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  ////////////////////
  // dac / adc controls
  ////////////////////

  // all three lag the state by one cycle
  // init only on the first chirp cycle before enable is up
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      chirp_init   <= 1'b0;
      chirp_enable <= 1'b0;
      adc_enable   <= 1'b0;
    end else begin
      chirp_init   <= (state == CHIRP) && !chirp_active && !chirp_enable;
      chirp_enable <= (state == CHIRP);
      adc_enable   <= (state == CHIRP) || (state == COLLECT);
    end
  end

  ////////////////////
  // checks
  ////////////////////

  a_init_one_cycle: assert property (
    @(posedge aclk) disable iff (!aresetn)
    chirp_init |=> !chirp_init
  ) else $error("chirp_init held longer than one cycle");

  // adc capture must cover the whole chirp
  a_enable_in_adc: assert property (
    @(posedge aclk) disable iff (!aresetn)
    chirp_enable |-> adc_enable
  ) else $error("chirp_enable without adc_enable");

  // zero samples would never leave collect
  a_samples_nonzero: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (state == IDLE && chirp_ready) |-> (collect_max != '0)
  ) else $error("zero adc sample count loaded");

endmodule

// File: param_shadow.sv
`timescale 1ns/1ps

`include "radar_cfg.svh"

module param_shadow #(
  parameter type      payload_t   = logic,
  parameter payload_t RESET_VALUE = '0
) (
  input  logic     aclk,
  input  logic     aresetn,
  input  payload_t din,
  output payload_t dout,
  output logic     updated
);

  ////////////////////
  // input stages
  ////////////////////

  // register-map values are quasi-static, two flops settle them
  payload_t stage1;
  payload_t stage2;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      stage1 <= RESET_VALUE;
      stage2 <= RESET_VALUE;
    end else begin
      stage1 <= din;
      stage2 <= stage1;
    end
  end

  ////////////////////
  // shadow copy
  ////////////////////

  // load only on change, flag the load for one cycle
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      dout    <= RESET_VALUE;
      updated <= 1'b0;
    end else if (stage2 != dout) begin
      dout    <= stage2;
      updated <= 1'b1;
    end else begin
      updated <= 1'b0;
    end
  end

  // payload is built from whole register-map words
  initial begin
    assert ($bits(payload_t) % `RADAR_WORD_W == 0)
      else $error("param_shadow payload is not a whole number of words");
  end

  // back-to-back loads need din to have moved three samples back
  a_no_double_update: assert property (
    @(posedge aclk) disable iff (!aresetn)
    (updated ##1 updated) |-> ($past(din, 3) != $past(din, 4))
  ) else $error("param_shadow updated twice with stable input");

endmodule

// File: radar_seq_pkg.sv
`include "radar_cfg.svh"

package radar_seq_pkg;

  // chirp cycle states
  // 3'b101 and 3'b110 stay unused
  typedef enum logic [2:0] {
    IDLE     = 3'b000,
    ACTIVE   = 3'b001,
    CHIRP    = 3'b010,
    COLLECT  = 3'b011,
    PROCESS  = 3'b100,
    OVERHEAD = 3'b111
  } seq_state_t;

  // longest fixed dwell sets the small counter width
  localparam int unsigned DWELL_MAX =
    (`RADAR_PROCESS_CYCLES > `RADAR_OVERHEAD_CYCLES) ?
    `RADAR_PROCESS_CYCLES : `RADAR_OVERHEAD_CYCLES;
  localparam int unsigned DWELL_W = $clog2(DWELL_MAX + 1);

  // process / overhead down counter
  typedef logic [DWELL_W-1:0] dwell_cnt_t;

endpackage

// File: radar_word_pkg.sv
`include "radar_cfg.svh"

package radar_word_pkg;

  // single register-map word
  typedef logic [`RADAR_WORD_W-1:0] radar_word_t;

  // interval count in aclk cycles, int word above frac word
  typedef logic [2*`RADAR_WORD_W-1:0] interval_t;

  // chirp shape, msb first as on the dac parameter bus
  typedef struct packed {
    radar_word_t ctrl_word;
    radar_word_t freq_offset;
    radar_word_t tuning_coef;
    radar_word_t counter_max;
  } chirp_params_t;

  // cycle timing words
  typedef struct packed {
    radar_word_t interval_int;
    radar_word_t interval_frac;
    radar_word_t adc_samples;
  } timing_cfg_t;

  localparam interval_t INTERVAL_RESET = `RADAR_INTERVAL_INIT;

  localparam chirp_params_t CHIRP_PARAMS_RESET = '{
    ctrl_word:   `RADAR_CHIRP_CTRL_INIT,
    freq_offset: `RADAR_CHIRP_FREQ_OFFSET_INIT,
    tuning_coef: `RADAR_CHIRP_TUNING_INIT,
    counter_max: `RADAR_CHIRP_COUNTER_MAX_INIT
  };

  localparam timing_cfg_t TIMING_CFG_RESET = '{
    interval_int:  INTERVAL_RESET[2*`RADAR_WORD_W-1:`RADAR_WORD_W],
    interval_frac: INTERVAL_RESET[`RADAR_WORD_W-1:0],
    adc_samples:   `RADAR_ADC_SAMPLES_INIT
  };

endpackage

// File: radar_cfg.svh
`ifndef RADAR_CFG_SVH
`define RADAR_CFG_SVH

////////////////////
// register-map words
////////////////////

// one register-map word
`define RADAR_WORD_W 32

// pulse repetition interval, integer word on top, fraction word below
`define RADAR_INTERVAL_INIT 64'h0000_0000_927c_0000

// adc collect length in aclk cycles
`define RADAR_ADC_SAMPLES_INIT 32'd200

// chirp shape defaults
`define RADAR_CHIRP_TUNING_INIT 32'h0000_0001
`define RADAR_CHIRP_COUNTER_MAX_INIT 32'h0000_0fff
`define RADAR_CHIRP_FREQ_OFFSET_INIT 32'h0000_0600
`define RADAR_CHIRP_CTRL_INIT 32'h0000_0020

////////////////////
// sequencer dwells
////////////////////

// cycles spent in process and overhead
`define RADAR_PROCESS_CYCLES 2
`define RADAR_OVERHEAD_CYCLES 2

`endif
